/* src/sample_pkg.sv */
package sample_pkg;

  ////////////////////////////////////////
  // channel count and widths
  ////////////////////////////////////////

  // two analog channels in each direction
  localparam int CHN = 2;

  // raw ADC pin word, lowest 2 bits reserved
  localparam int ADC_W = 16;
  // calibrated sample and DAC code width
  localparam int SMP_W = 14;

  ////////////////////////////////////////
  // sample types
  ////////////////////////////////////////

  typedef logic        [ADC_W-1:0] adc_raw_t;
  typedef logic signed [SMP_W-1:0] sample_t;
  // unsigned code, negative slope
  typedef logic        [SMP_W-1:0] dac_code_t;

  // saturation limits of a signed 14 bit sample
  localparam int SAMPLE_MAX = 8191;
  localparam int SAMPLE_MIN = -8192;

  // DAC code that outputs a zero sample
  localparam dac_code_t DAC_ZERO = 14'h1fff;

endpackage

/* src/calib_pkg.sv */
package calib_pkg;

  ////////////////////////////////////////
  // calibration types
  ////////////////////////////////////////

  localparam int MUL_W = 16;
  localparam int SUM_W = 14;

  // gain, 1.0 is 16'h4000
  typedef logic signed [MUL_W-1:0] cal_mul_t;
  // offset in sample units
  typedef logic signed [SUM_W-1:0] cal_sum_t;

  // product is scaled back by 2^14
  localparam int MUL_SHIFT = 14;

  // register reset values
  localparam cal_mul_t MUL_UNITY = 16'h4000;
  localparam cal_sum_t SUM_RESET = 14'sd0;

  ////////////////////////////////////////
  // configuration port and address map
  ////////////////////////////////////////

  localparam int CFG_AW = 4;
  localparam int CFG_DW = 16;

  typedef logic [CFG_AW-1:0] cfg_addr_t;
  typedef logic [CFG_DW-1:0] cfg_data_t;

  // ADC side gain/offset pairs
  localparam cfg_addr_t ADR_ADC_MUL0 = 4'd0;
  localparam cfg_addr_t ADR_ADC_SUM0 = 4'd1;
  localparam cfg_addr_t ADR_ADC_MUL1 = 4'd2;
  localparam cfg_addr_t ADR_ADC_SUM1 = 4'd3;
  // DAC side gain/offset pairs
  localparam cfg_addr_t ADR_DAC_MUL0 = 4'd4;
  localparam cfg_addr_t ADR_DAC_SUM0 = 4'd5;
  localparam cfg_addr_t ADR_DAC_MUL1 = 4'd6;
  localparam cfg_addr_t ADR_DAC_SUM1 = 4'd7;
  // loopback enables, bit i for channel i
  localparam cfg_addr_t ADR_LOOP     = 4'd8;

endpackage

/* src/frontend_regs.sv */
module frontend_regs
  import sample_pkg::*;
  import calib_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   top_rst,
  // configuration strobes
  input  logic                   cfg_wr_i,
  input  logic                   cfg_rd_i,
  input  cfg_addr_t              cfg_addr_i,
  input  cfg_data_t              cfg_wdata_i,
  output cfg_data_t              cfg_rdata_o,
  // calibration settings
  output cal_mul_t [CHN-1:0]     adc_mul_o,
  output cal_sum_t [CHN-1:0]     adc_sum_o,
  output cal_mul_t [CHN-1:0]     dac_mul_o,
  output cal_sum_t [CHN-1:0]     dac_sum_o,
  // loopback enables
  output logic     [CHN-1:0]     loop_o
);

  // read data before the output register
  cfg_data_t rd_dat;

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_mul_o <= {CHN{MUL_UNITY}};
      adc_sum_o <= {CHN{SUM_RESET}};
      dac_mul_o <= {CHN{MUL_UNITY}};
      dac_sum_o <= {CHN{SUM_RESET}};
      loop_o    <= '0;
    end else if (cfg_wr_i) begin
      // offsets keep only the low 14 bits
      case (cfg_addr_i)
        ADR_ADC_MUL0: adc_mul_o[0] <= cfg_wdata_i;
        ADR_ADC_SUM0: adc_sum_o[0] <= cfg_wdata_i[SUM_W-1:0];
        ADR_ADC_MUL1: adc_mul_o[1] <= cfg_wdata_i;
        ADR_ADC_SUM1: adc_sum_o[1] <= cfg_wdata_i[SUM_W-1:0];
        ADR_DAC_MUL0: dac_mul_o[0] <= cfg_wdata_i;
        ADR_DAC_SUM0: dac_sum_o[0] <= cfg_wdata_i[SUM_W-1:0];
        ADR_DAC_MUL1: dac_mul_o[1] <= cfg_wdata_i;
        ADR_DAC_SUM1: dac_sum_o[1] <= cfg_wdata_i[SUM_W-1:0];
        ADR_LOOP:     loop_o       <= cfg_wdata_i[CHN-1:0];
        // unmapped, nothing changes
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // read multiplexer
  ////////////////////////////////////////

  // offsets come back sign extended, loop bits zero extended
  always_comb begin
    case (cfg_addr_i)
      ADR_ADC_MUL0: rd_dat = cfg_data_t'(adc_mul_o[0]);
      ADR_ADC_SUM0: rd_dat = cfg_data_t'(adc_sum_o[0]);
      ADR_ADC_MUL1: rd_dat = cfg_data_t'(adc_mul_o[1]);
      ADR_ADC_SUM1: rd_dat = cfg_data_t'(adc_sum_o[1]);
      ADR_DAC_MUL0: rd_dat = cfg_data_t'(dac_mul_o[0]);
      ADR_DAC_SUM0: rd_dat = cfg_data_t'(dac_sum_o[0]);
      ADR_DAC_MUL1: rd_dat = cfg_data_t'(dac_mul_o[1]);
      ADR_DAC_SUM1: rd_dat = cfg_data_t'(dac_sum_o[1]);
      ADR_LOOP:     rd_dat = cfg_data_t'(loop_o);
      // unmapped reads as zero
      default:      rd_dat = '0;
    endcase
  end

  // read data lands one cycle after the strobe
  // and holds until the next one
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cfg_rdata_o <= '0;
    end else if (cfg_rd_i) begin
      cfg_rdata_o <= rd_dat;
    end
  end

endmodule

/* src/adc_decode.sv */
module adc_decode
  import sample_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   top_rst,
  // raw ADC pins
  input  adc_raw_t [CHN-1:0]     adc_dat_i,
  // calibrated DAC samples for loopback
  input  sample_t  [CHN-1:0]     loop_dat_i,
  input  logic     [CHN-1:0]     loop_i,
  // decoded sample stream
  output sample_t  [CHN-1:0]     dec_dat_o
);

  // capture register, one per channel
  sample_t [CHN-1:0] raw_q;

  ////////////////////////////////////////
  // capture and sign decode
  ////////////////////////////////////////

  // msb kept, the rest inverted
  // reserved low bits are dropped
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      raw_q <= '0;
    end else begin
      for (int i = 0; i < CHN; i++) begin
        raw_q[i] <= {adc_dat_i[i][ADC_W-1], ~adc_dat_i[i][ADC_W-2:ADC_W-SMP_W]};
      end
    end
  end

  ////////////////////////////////////////
  // digital loopback
  ////////////////////////////////////////

  // combinational, adds no cycle to the DAC path
  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      dec_dat_o[i] = loop_i[i] ? loop_dat_i[i] : raw_q[i];
    end
  end

endmodule

/* src/calib_linear.sv */
module calib_linear
  import sample_pkg::*;
  import calib_pkg::*;
(
  input  logic     adc_clk,
  input  logic     top_rst,
  // sample in
  input  sample_t  dat_i,
  // gain and offset
  input  cal_mul_t mul_i,
  input  cal_sum_t sum_i,
  // calibrated sample out
  output sample_t  dat_o
);

  // full product, 14 x 16 bits
  logic signed [SMP_W+MUL_W-1:0]           prd;
  logic signed [SMP_W+MUL_W-1:0]           prd_shf;
  // scaled product, stage one register
  logic signed [SMP_W+MUL_W-MUL_SHIFT-1:0] shf_q;
  // offset sum, one guard bit
  logic signed [SMP_W+MUL_W-MUL_SHIFT:0]   add;
  sample_t                                 sat;

  ////////////////////////////////////////
  // stage one, gain
  ////////////////////////////////////////

  // signed multiply then arithmetic shift
  assign prd     = dat_i * mul_i;
  assign prd_shf = prd >>> MUL_SHIFT;

  // upper bits after the shift are only sign copies
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      shf_q <= '0;
    end else begin
      shf_q <= prd_shf[SMP_W+MUL_W-MUL_SHIFT-1:0];
    end
  end

  ////////////////////////////////////////
  // stage two, offset and clamp
  ////////////////////////////////////////

  assign add = shf_q + sum_i;

  // clamp into the 14 bit sample range
  always_comb begin
    if (add > SAMPLE_MAX) begin
      sat = sample_t'(SAMPLE_MAX);
    end else if (add < SAMPLE_MIN) begin
      sat = sample_t'(SAMPLE_MIN);
    end else begin
      sat = add[SMP_W-1:0];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else begin
      dat_o <= sat;
    end
  end

endmodule

/* src/dac_encode.sv */
module dac_encode
  import sample_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   top_rst,
  // calibrated generator samples
  input  sample_t   [CHN-1:0]    dat_i,
  // DAC pin codes
  output dac_code_t [CHN-1:0]    dac_dat_o
);

  ////////////////////////////////////////
  // signed to negative slope code
  ////////////////////////////////////////

  // sign bit kept, magnitude bits inverted
  // output register sits next to the pins
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= {CHN{DAC_ZERO}};
    end else begin
      for (int i = 0; i < CHN; i++) begin
        dac_dat_o[i] <= {dat_i[i][SMP_W-1], ~dat_i[i][SMP_W-2:0]};
      end
    end
  end

endmodule

/* src/frontend_top.sv */
module frontend_top
  import sample_pkg::*;
  import calib_pkg::*;
(
  input  logic                   adc_clk,
  input  logic                   top_rst,
  // ADC pins
  input  adc_raw_t  [CHN-1:0]    adc_dat_i,
  // generator samples
  input  sample_t   [CHN-1:0]    gen_dat_i,
  // configuration strobes
  input  logic                   cfg_wr_i,
  input  logic                   cfg_rd_i,
  input  cfg_addr_t              cfg_addr_i,
  input  cfg_data_t              cfg_wdata_i,
  output cfg_data_t              cfg_rdata_o,
  // calibrated acquisition samples
  output sample_t   [CHN-1:0]    osc_dat_o,
  // DAC pins, one port per channel
  output dac_code_t [CHN-1:0]    dac_dat_o
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  // calibration settings
  cal_mul_t [CHN-1:0] adc_mul;
  cal_sum_t [CHN-1:0] adc_sum;
  cal_mul_t [CHN-1:0] dac_mul;
  cal_sum_t [CHN-1:0] dac_sum;
  // loopback enables
  logic     [CHN-1:0] loop;

  // decoded ADC stream, after loopback mux
  sample_t  [CHN-1:0] dec_dat;
  // calibrated DAC stream
  sample_t  [CHN-1:0] dac_cal;

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  frontend_regs u_frontend_regs (
    .adc_clk     (adc_clk    ),
    .top_rst     (top_rst    ),
    .cfg_wr_i    (cfg_wr_i   ),
    .cfg_rd_i    (cfg_rd_i   ),
    .cfg_addr_i  (cfg_addr_i ),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .adc_mul_o   (adc_mul    ),
    .adc_sum_o   (adc_sum    ),
    .dac_mul_o   (dac_mul    ),
    .dac_sum_o   (dac_sum    ),
    .loop_o      (loop       )
  );

  ////////////////////////////////////////
  // generator path
  ////////////////////////////////////////

  // DAC calibration, 2 cycles
  for (genvar i = 0; i < CHN; i++) begin : for_dac
    calib_linear u_calib_dac (
      .adc_clk (adc_clk   ),
      .top_rst (top_rst   ),
      .dat_i   (gen_dat_i[i]),
      .mul_i   (dac_mul[i]),
      .sum_i   (dac_sum[i]),
      .dat_o   (dac_cal[i])
    );
  end : for_dac

  // DAC code register, 1 cycle
  dac_encode u_dac_encode (
    .adc_clk   (adc_clk  ),
    .top_rst   (top_rst  ),
    .dat_i     (dac_cal  ),
    .dac_dat_o (dac_dat_o)
  );

  ////////////////////////////////////////
  // acquisition path
  ////////////////////////////////////////

  // capture plus loopback from the calibrated DAC stream
  adc_decode u_adc_decode (
    .adc_clk    (adc_clk  ),
    .top_rst    (top_rst  ),
    .adc_dat_i  (adc_dat_i),
    .loop_dat_i (dac_cal  ),
    .loop_i     (loop     ),
    .dec_dat_o  (dec_dat  )
  );

  // ADC calibration, 2 cycles
  for (genvar i = 0; i < CHN; i++) begin : for_adc
    calib_linear u_calib_adc (
      .adc_clk (adc_clk     ),
      .top_rst (top_rst     ),
      .dat_i   (dec_dat[i]  ),
      .mul_i   (adc_mul[i]  ),
      .sum_i   (adc_sum[i]  ),
      .dat_o   (osc_dat_o[i])
    );
  end : for_adc

endmodule

/* verif/frontend_tb.sv */
module frontend_tb
  import sample_pkg::*;
  import calib_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // run constants
  ////////////////////////////////////////

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYC    = 10;
  // longest path of 4 cycles plus one
  localparam int HOLD_CYC   = 5;
  localparam int N_HAND     = 4;
  localparam int N_RAND     = 24;
  localparam int N_UNITY    = 8;
  // 9 writes and 16 reads then the hold
  localparam int CYC_PER_ROW = 9 + 16 + HOLD_CYC;
  // reset, reset readback, unmapped writes and readback
  localparam int CYC_START   = RST_CYC + 16 + 7 + 16;
  localparam int WD_CYC      = (N_HAND + N_RAND) * CYC_PER_ROW + CYC_START + 100;
  localparam logic [31:0] SEED = 32'hfd57aead;

  // one table row of settings, stimulus and expected outputs
  typedef struct {
    logic      [CHN-1:0] loop;
    cal_mul_t  [CHN-1:0] adc_mul;
    cal_sum_t  [CHN-1:0] adc_sum;
    cal_mul_t  [CHN-1:0] dac_mul;
    cal_sum_t  [CHN-1:0] dac_sum;
    adc_raw_t  [CHN-1:0] raw;
    sample_t   [CHN-1:0] gen;
    sample_t   [CHN-1:0] exp_osc;
    dac_code_t [CHN-1:0] exp_dac;
  } row_t;

  logic                adc_clk;
  logic                top_rst;
  adc_raw_t  [CHN-1:0] adc_dat_i;
  sample_t   [CHN-1:0] gen_dat_i;
  logic                cfg_wr_i;
  logic                cfg_rd_i;
  cfg_addr_t           cfg_addr_i;
  cfg_data_t           cfg_wdata_i;
  cfg_data_t           cfg_rdata_o;
  sample_t   [CHN-1:0] osc_dat_o;
  dac_code_t [CHN-1:0] dac_dat_o;

  row_t      rows [$];
  // expected readback per address
  // unmapped addresses stay zero
  cfg_data_t shadow [16];

  frontend_top u_frontend_top (
    .adc_clk     (adc_clk    ),
    .top_rst     (top_rst    ),
    .adc_dat_i   (adc_dat_i  ),
    .gen_dat_i   (gen_dat_i  ),
    .cfg_wr_i    (cfg_wr_i   ),
    .cfg_rd_i    (cfg_rd_i   ),
    .cfg_addr_i  (cfg_addr_i ),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .osc_dat_o   (osc_dat_o  ),
    .dac_dat_o   (dac_dat_o  )
  );

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // bits 15..2 as one field with the low 13 flipped
  function automatic sample_t decode_raw(input adc_raw_t raw);
    return sample_t'(raw >> 2) ^ sample_t'(14'h1fff);
  endfunction

  // same flip on the signed sample
  function automatic dac_code_t encode_sample(input sample_t s);
    return dac_code_t'(s) ^ dac_code_t'(14'h1fff);
  endfunction

  // integer math with floor shift then offset and clamp
  function automatic sample_t calibrate(input sample_t s, input cal_mul_t g,
                                        input cal_sum_t o);
    longint r;
    r = (longint'(s) * longint'(g)) >>> MUL_SHIFT;
    r = r + longint'(o);
    if (r > SAMPLE_MAX) begin
      r = SAMPLE_MAX;
    end else if (r < SAMPLE_MIN) begin
      r = SAMPLE_MIN;
    end
    return sample_t'(r);
  endfunction

  function automatic row_t with_expect(input row_t r);
    sample_t dac_s;
    sample_t src;
    for (int i = 0; i < CHN; i++) begin
      dac_s = calibrate(r.gen[i], r.dac_mul[i], r.dac_sum[i]);
      // loopback takes the calibrated generator sample
      src = r.loop[i] ? dac_s : decode_raw(r.raw[i]);
      r.exp_osc[i] = calibrate(src, r.adc_mul[i], r.adc_sum[i]);
      r.exp_dac[i] = encode_sample(dac_s);
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // table construction
  ////////////////////////////////////////

  function automatic row_t make_row(
    input logic [CHN-1:0] loop,
    input cal_mul_t [CHN-1:0] adc_mul, input cal_sum_t [CHN-1:0] adc_sum,
    input cal_mul_t [CHN-1:0] dac_mul, input cal_sum_t [CHN-1:0] dac_sum,
    input adc_raw_t [CHN-1:0] raw, input sample_t [CHN-1:0] gen,
    input sample_t [CHN-1:0] exp_osc, input dac_code_t [CHN-1:0] exp_dac);
    row_t r;
    r.loop    = loop;
    r.adc_mul = adc_mul;
    r.adc_sum = adc_sum;
    r.dac_mul = dac_mul;
    r.dac_sum = dac_sum;
    r.raw     = raw;
    r.gen     = gen;
    r.exp_osc = exp_osc;
    r.exp_dac = exp_dac;
    return r;
  endfunction

  // unity rows keep loopback off and plain decode
  function automatic row_t random_row(input bit unity);
    row_t r;
    for (int i = 0; i < CHN; i++) begin
      r.adc_mul[i] = unity ? MUL_UNITY : cal_mul_t'($urandom);
      r.adc_sum[i] = unity ? SUM_RESET : cal_sum_t'($urandom);
      r.dac_mul[i] = cal_mul_t'($urandom);
      r.dac_sum[i] = cal_sum_t'($urandom);
      r.raw[i]     = adc_raw_t'($urandom);
      r.gen[i]     = sample_t'($urandom);
    end
    r.loop = unity ? '0 : CHN'($urandom);
    return with_expect(r);
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_cfg(input string name, input cfg_data_t got, input cfg_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // register access at a falling edge
  ////////////////////////////////////////

  // offsets keep 14 bits, loop keeps 2, unmapped keeps nothing
  task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
    cfg_wr_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(negedge adc_clk);
    cfg_wr_i = 1'b0;
    if (addr == ADR_LOOP) begin
      shadow[addr] = {14'h0, data[1:0]};
    end else if (addr < ADR_LOOP && addr[0]) begin
      shadow[addr] = {{2{data[13]}}, data[13:0]};
    end else if (addr < ADR_LOOP) begin
      shadow[addr] = data;
    end
  endtask

  task automatic read_reg(input cfg_addr_t addr);
    cfg_rd_i   = 1'b1;
    cfg_addr_i = addr;
    @(negedge adc_clk);
    cfg_rd_i = 1'b0;
    check_cfg($sformatf("cfg_rdata_o at address %0d", addr), cfg_rdata_o, shadow[addr]);
  endtask

  task automatic read_all();
    for (int a = 0; a < 16; a++) begin
      read_reg(cfg_addr_t'(a));
    end
  endtask

  // offset word with junk above bit 13
  function automatic cfg_data_t sum_word(input cal_sum_t s);
    return {~{2{s[SUM_W-1]}}, s};
  endfunction

  task automatic run_row(input row_t r);
    write_reg(ADR_ADC_MUL0, r.adc_mul[0]);
    write_reg(ADR_ADC_SUM0, sum_word(r.adc_sum[0]));
    write_reg(ADR_ADC_MUL1, r.adc_mul[1]);
    write_reg(ADR_ADC_SUM1, sum_word(r.adc_sum[1]));
    write_reg(ADR_DAC_MUL0, r.dac_mul[0]);
    write_reg(ADR_DAC_SUM0, sum_word(r.dac_sum[0]));
    write_reg(ADR_DAC_MUL1, r.dac_mul[1]);
    write_reg(ADR_DAC_SUM1, sum_word(r.dac_sum[1]));
    write_reg(ADR_LOOP, {14'h2a5a, r.loop});
    read_all();
    // new samples then a hold just past the longest path
    adc_dat_i = r.raw;
    gen_dat_i = r.gen;
    repeat (HOLD_CYC) @(negedge adc_clk);
    for (int i = 0; i < CHN; i++) begin
      check_sample($sformatf("osc_dat_o[%0d]", i), osc_dat_o[i], r.exp_osc[i]);
      check_code($sformatf("dac_dat_o[%0d]", i), dac_dat_o[i], r.exp_dac[i]);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    adc_clk     = 1'b0;
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    gen_dat_i   = '0;
    cfg_wr_i    = 1'b0;
    cfg_rd_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    for (int a = 0; a < 16; a++) begin
      shadow[a] = '0;
    end
    // gains come out of reset at 1.0
    shadow[ADR_ADC_MUL0] = MUL_UNITY;
    shadow[ADR_ADC_MUL1] = MUL_UNITY;
    shadow[ADR_DAC_MUL0] = MUL_UNITY;
    shadow[ADR_DAC_MUL1] = MUL_UNITY;

    // hand rows for unity decode, saturation, per channel gain and loopback on ch1
    rows.push_back(make_row(2'b00, {2{MUL_UNITY}}, '0, {2{MUL_UNITY}}, '0,
      {16'h7ffc, 16'h8000}, '0, {14'h0000, 14'h3fff}, {14'h1fff, 14'h1fff}));
    rows.push_back(make_row(2'b00, {2{MUL_UNITY}}, {14'h0001, 14'h3fff},
      {16'h7fff, 16'h7fff}, '0, {16'h0000, 16'hfffc}, {14'h2c78, 14'h1388},
      {14'h1fff, 14'h2000}, {14'h3fff, 14'h0000}));
    rows.push_back(make_row(2'b00, {16'hc000, 16'h2000}, {14'h3fce, 14'h0064},
      {2{MUL_UNITY}}, '0, {16'h705f, 16'h705c}, '0,
      {14'h3be6, 14'h0258}, {14'h1fff, 14'h1fff}));
    rows.push_back(make_row(2'b10, {16'h8000, 16'h4000}, '0, {2{MUL_UNITY}},
      {14'h00c8, 14'h0000}, {16'h0000, 16'h705c}, {14'h012c, 14'h0000},
      {14'h3c18, 14'h03e8}, {14'h1e0b, 14'h1fff}));
    for (int n = 0; n < N_RAND; n++) begin
      rows.push_back(random_row(n < N_UNITY));
    end

    // outputs must sit at their reset values
    repeat (RST_CYC) @(negedge adc_clk);
    for (int i = 0; i < CHN; i++) begin
      check_sample($sformatf("osc_dat_o[%0d]", i), osc_dat_o[i], '0);
      check_code($sformatf("dac_dat_o[%0d]", i), dac_dat_o[i], 14'h1fff);
    end
    check_cfg("cfg_rdata_o", cfg_rdata_o, '0);
    top_rst = 1'b0;
    @(negedge adc_clk);
    read_all();

    // unmapped writes leave every register alone
    for (int a = 9; a < 16; a++) begin
      write_reg(cfg_addr_t'(a), 16'hffff);
    end
    read_all();

    foreach (rows[n]) begin
      run_row(rows[n]);
    end

    $display("Test OK");
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    #(WD_CYC * CLK_PERIOD);
    abort_run($sformatf("timeout, run did not finish within %0d cycles", WD_CYC));
  end

endmodule

/* project.f */
src/sample_pkg.sv
src/calib_pkg.sv
src/frontend_regs.sv
src/adc_decode.sv
src/calib_linear.sv
src/dac_encode.sv
src/frontend_top.sv
verif/frontend_tb.sv
